// File: Makefile
TOP := tb_exu
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o vsim
	./obj_dir/vsim 2>&1 | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: common/exu_consts.svh
// Width and size constants of the execution stage, included by the package and every RTL file
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

////////////////////////////////////////////////////////////
// Datapath

// Data and address width
`define EXU_XLEN       32
`define EXU_INSTR_W    32

// Register file, x0 counted
`define EXU_RFIDX_W    5
`define EXU_RF_NUM     32

////////////////////////////////////////////////////////////
// Outstanding instruction FIFO

// Loads in flight
`define EXU_OITF_DEPTH 4
// Must cover the depth
`define EXU_ITAG_W     2

`endif

// File: common/exu_pkg.sv
// Enums and packed structs of the execution stage, reached through exu_pkg:: scoped names
`default_nettype none

`include "exu_consts.svh"

package exu_pkg;

  ////////////////////////////////////////////////////////////
  // Encodings

  // RV32I major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Bundles

  // Instruction from fetch
  typedef struct packed {
    logic [`EXU_XLEN-1:0]    pc;
    logic [`EXU_INSTR_W-1:0] ir;
  } instr_t;

  // Load command towards the LSU
  typedef struct packed {
    logic [`EXU_XLEN-1:0]   addr;
    logic [`EXU_ITAG_W-1:0] itag;  // OITF entry of the load
  } lsu_cmd_t;

  // Long-pipe return from the LSU
  typedef struct packed {
    logic [`EXU_XLEN-1:0]   wdat;
    logic [`EXU_ITAG_W-1:0] itag;
  } lsu_wbck_t;

  // One register file write
  typedef struct packed {
    logic [`EXU_RFIDX_W-1:0] rdidx;
    logic [`EXU_XLEN-1:0]    wdat;
  } rf_wbck_t;

endpackage

`default_nettype wire

// File: design/exu_regfile.sv
// Integer register file with x0 tied to zero, two read ports and one write port
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_regfile (
  input  wire                          clk,
  input  wire                          i_rst_n,
  // Read ports, combinational
  input  wire [`EXU_RFIDX_W-1:0]       i_rs1idx,
  input  wire [`EXU_RFIDX_W-1:0]       i_rs2idx,
  output logic [`EXU_XLEN-1:0]         o_rs1_dat,
  output logic [`EXU_XLEN-1:0]         o_rs2_dat,
  // Write port
  input  wire                          i_wen,
  input  wire exu_pkg::rf_wbck_t       i_wbck
);

  // x1 to x31 only
  logic [`EXU_XLEN-1:0] rf_q [1:`EXU_RF_NUM-1];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < `EXU_RF_NUM; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wen) begin
      for (int i = 1; i < `EXU_RF_NUM; i++) begin
        if (i_wbck.rdidx == `EXU_RFIDX_W'(i)) begin
          rf_q[i] <= i_wbck.wdat;  // A write to x0 matches nothing
        end
      end
    end
  end

  assign o_rs1_dat = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2_dat = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

`default_nettype wire

// File: design/exu_top.sv
// Top of the execution stage, connecting dispatch, OITF, write-back and the register file
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_top (
  input  wire                          clk,
  input  wire                          i_rst_n,
  // Fetch side
  input  wire                          i_instr_valid,
  input  wire exu_pkg::instr_t         i_instr,
  output wire                          o_instr_ready,
  // Load command
  output wire                          o_lsu_cmd_valid,
  output wire exu_pkg::lsu_cmd_t       o_lsu_cmd,
  input  wire                          i_lsu_cmd_ready,
  // Long-pipe return, one pulse per load
  input  wire                          i_lsu_wbck_valid,
  input  wire exu_pkg::lsu_wbck_t      i_lsu_wbck,
  // Register file write trace
  output wire                          o_rf_wbck_ena,
  output wire exu_pkg::rf_wbck_t       o_rf_wbck
);

  wire [`EXU_XLEN-1:0]    rs1_dat;
  wire [`EXU_XLEN-1:0]    rs2_dat;
  wire [`EXU_RFIDX_W-1:0] rs1idx;
  wire [`EXU_RFIDX_W-1:0] rs2idx;
  wire [`EXU_RFIDX_W-1:0] disp_rdidx;
  wire                    rs1en;
  wire                    rs2en;
  wire                    rdwen;

  wire                    disp_oitf_ena;
  wire                    oitf_hazard;
  wire                    oitf_full;
  wire [`EXU_ITAG_W-1:0]  oitf_itag;
  wire [`EXU_RFIDX_W-1:0] ret_rdidx;
  wire                    ret_ena;

  wire                    alu_wbck_valid;
  wire exu_pkg::rf_wbck_t alu_wbck;
  wire                    alu_wbck_ready;

  ////////////////////////////////////////////////////////////
  // Dispatch (producer)
  exu_disp u_exu_disp (
    .i_instr_valid    (i_instr_valid),
    .i_instr          (i_instr),
    .o_instr_ready    (o_instr_ready),
    .i_rs1_dat        (rs1_dat),
    .i_rs2_dat        (rs2_dat),
    .o_rs1idx         (rs1idx),
    .o_rs2idx         (rs2idx),
    .o_rdidx          (disp_rdidx),
    .o_rs1en          (rs1en),
    .o_rs2en          (rs2en),
    .o_rdwen          (rdwen),
    .i_oitf_hazard    (oitf_hazard),
    .i_oitf_full      (oitf_full),
    .i_oitf_itag      (oitf_itag),
    .o_oitf_ena       (disp_oitf_ena),
    .o_lsu_cmd_valid  (o_lsu_cmd_valid),
    .o_lsu_cmd        (o_lsu_cmd),
    .i_lsu_cmd_ready  (i_lsu_cmd_ready),
    .o_alu_wbck_valid (alu_wbck_valid),
    .o_alu_wbck       (alu_wbck),
    .i_alu_wbck_ready (alu_wbck_ready)
  );

  ////////////////////////////////////////////////////////////
  // OITF (buffer)
  exu_oitf u_exu_oitf (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_dis_ena   (disp_oitf_ena),
    .i_dis_rdidx (disp_rdidx),
    .i_rs1idx    (rs1idx),
    .i_rs2idx    (rs2idx),
    .i_rdidx     (disp_rdidx),   // Same index checked for WAW
    .i_rs1en     (rs1en),
    .i_rs2en     (rs2en),
    .i_rdwen     (rdwen),
    .o_hazard    (oitf_hazard),
    .o_full      (oitf_full),
    .o_dis_itag  (oitf_itag),
    .i_ret_ena   (ret_ena),
    .o_ret_rdidx (ret_rdidx)
  );

  ////////////////////////////////////////////////////////////
  // Write-back (consumer)
  exu_wbck u_exu_wbck (
    .i_lsu_wbck_valid (i_lsu_wbck_valid),
    .i_lsu_wbck       (i_lsu_wbck),
    .i_ret_rdidx      (ret_rdidx),
    .i_alu_wbck_valid (alu_wbck_valid),
    .i_alu_wbck       (alu_wbck),
    .o_alu_wbck_ready (alu_wbck_ready),
    .o_ret_ena        (ret_ena),
    .o_rf_ena         (o_rf_wbck_ena),
    .o_rf_wbck        (o_rf_wbck)
  );

  exu_regfile u_exu_regfile (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_rs1idx  (rs1idx),
    .i_rs2idx  (rs2idx),
    .o_rs1_dat (rs1_dat),
    .o_rs2_dat (rs2_dat),
    .i_wen     (o_rf_wbck_ena),
    .i_wbck    (o_rf_wbck)
  );

endmodule

`default_nettype wire

// File: design/exu_wbck.sv
// Write-back arbiter giving returning loads priority over ALU results into the register file
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_wbck (
  // Long-pipe return, no ready since it always wins
  input  wire                          i_lsu_wbck_valid,
  input  wire exu_pkg::lsu_wbck_t      i_lsu_wbck,
  input  wire [`EXU_RFIDX_W-1:0]       i_ret_rdidx,
  // ALU result
  input  wire                          i_alu_wbck_valid,
  input  wire exu_pkg::rf_wbck_t       i_alu_wbck,
  output logic                         o_alu_wbck_ready,
  // OITF retirement
  output logic                         o_ret_ena,
  // Register file write
  output logic                         o_rf_ena,
  output exu_pkg::rf_wbck_t            o_rf_wbck
);

  assign o_ret_ena        = i_lsu_wbck_valid;
  assign o_alu_wbck_ready = ~i_lsu_wbck_valid;  // ALU stalls for one cycle

  always_comb begin
    if (i_lsu_wbck_valid) begin
      // Loads return in order so the head owns this data
      o_rf_ena        = (i_ret_rdidx != '0);
      o_rf_wbck.rdidx = i_ret_rdidx;
      o_rf_wbck.wdat  = i_lsu_wbck.wdat;
    end else begin
      o_rf_ena  = i_alu_wbck_valid;
      o_rf_wbck = i_alu_wbck;
    end
  end

endmodule

`default_nettype wire

// File: exu_disp/exu_disp.sv
// Decode and dispatch of the RV32I subset, sending ALU results to write-back and loads to the LSU
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_disp (
  // Instruction from fetch
  input  wire                          i_instr_valid,
  input  wire exu_pkg::instr_t         i_instr,
  output logic                         o_instr_ready,
  // Register file read
  input  wire [`EXU_XLEN-1:0]          i_rs1_dat,
  input  wire [`EXU_XLEN-1:0]          i_rs2_dat,
  output logic [`EXU_RFIDX_W-1:0]      o_rs1idx,
  output logic [`EXU_RFIDX_W-1:0]      o_rs2idx,
  output logic [`EXU_RFIDX_W-1:0]      o_rdidx,
  output logic                         o_rs1en,
  output logic                         o_rs2en,
  output logic                         o_rdwen,
  // OITF
  input  wire                          i_oitf_hazard,
  input  wire                          i_oitf_full,
  input  wire [`EXU_ITAG_W-1:0]        i_oitf_itag,
  output logic                         o_oitf_ena,
  // Load command
  output logic                         o_lsu_cmd_valid,
  output exu_pkg::lsu_cmd_t            o_lsu_cmd,
  input  wire                          i_lsu_cmd_ready,
  // ALU write-back
  output logic                         o_alu_wbck_valid,
  output exu_pkg::rf_wbck_t            o_alu_wbck,
  input  wire                          i_alu_wbck_ready
);

  logic [`EXU_INSTR_W-1:0] ir;
  exu_pkg::opcode_e        opc;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [`EXU_XLEN-1:0]    imm;
  logic                    op_ok;
  logic                    imm_ok;
  logic                    ld_ok;
  logic                    is_alu;
  exu_pkg::alu_op_e        alu_op;
  logic [`EXU_XLEN-1:0]    op2;
  logic [`EXU_XLEN-1:0]    alu_res;

  ////////////////////////////////////////////////////////////
  // Decode

  assign ir     = i_instr.ir;
  assign opc    = exu_pkg::opcode_e'(ir[6:0]);
  assign funct3 = ir[14:12];
  assign funct7 = ir[31:25];
  assign imm    = {{(`EXU_XLEN-12){ir[31]}}, ir[31:20]};  // Sign-extended I-immediate

  // Anything outside the exact subset is taken as a no-op
  assign op_ok  = (opc == exu_pkg::OPC_OP) &
                  (((funct7 == 7'b0000000) & (funct3 inside {3'b000, 3'b100, 3'b110, 3'b111})) |
                   ((funct7 == 7'b0100000) & (funct3 == 3'b000)));
  assign imm_ok = (opc == exu_pkg::OPC_OP_IMM) &
                  (funct3 inside {3'b000, 3'b100, 3'b110, 3'b111});
  assign ld_ok  = (opc == exu_pkg::OPC_LOAD) & (funct3 == 3'b010);  // LW only
  assign is_alu = op_ok | imm_ok;

  assign o_rs1idx = ir[19:15];
  assign o_rs2idx = ir[24:20];
  assign o_rdidx  = ir[11:7];

  // x0 never takes part in a hazard
  assign o_rs1en = (is_alu | ld_ok) & (o_rs1idx != '0);
  assign o_rs2en = op_ok & (o_rs2idx != '0);
  assign o_rdwen = (is_alu | ld_ok) & (o_rdidx != '0);

  ////////////////////////////////////////////////////////////
  // ALU

  always_comb begin
    case (funct3)
      3'b100:  alu_op = exu_pkg::ALU_XOR;
      3'b110:  alu_op = exu_pkg::ALU_OR;
      3'b111:  alu_op = exu_pkg::ALU_AND;
      default: alu_op = (op_ok & funct7[5]) ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
    endcase
  end

  assign op2 = op_ok ? i_rs2_dat : imm;

  always_comb begin
    case (alu_op)
      exu_pkg::ALU_SUB: alu_res = i_rs1_dat - op2;
      exu_pkg::ALU_AND: alu_res = i_rs1_dat & op2;
      exu_pkg::ALU_OR:  alu_res = i_rs1_dat | op2;
      exu_pkg::ALU_XOR: alu_res = i_rs1_dat ^ op2;
      default:          alu_res = i_rs1_dat + op2;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Issue

  assign o_alu_wbck_valid = i_instr_valid & is_alu & o_rdwen & ~i_oitf_hazard;
  assign o_alu_wbck.rdidx = o_rdidx;
  assign o_alu_wbck.wdat  = alu_res;

  // Raised without looking at ready
  assign o_lsu_cmd_valid = i_instr_valid & ld_ok & ~i_oitf_hazard & ~i_oitf_full;
  assign o_lsu_cmd.addr  = i_rs1_dat + imm;
  assign o_lsu_cmd.itag  = i_oitf_itag;
  assign o_oitf_ena      = o_lsu_cmd_valid & i_lsu_cmd_ready;  // Allocate on handshake

  always_comb begin
    if (i_oitf_hazard) begin
      o_instr_ready = 1'b0;
    end else if (ld_ok) begin
      o_instr_ready = ~i_oitf_full & i_lsu_cmd_ready;
    end else if (is_alu & o_rdwen) begin
      o_instr_ready = i_alu_wbck_ready;
    end else begin
      o_instr_ready = 1'b1;  // Nothing to write
    end
  end

endmodule

`default_nettype wire

// File: exu_oitf/exu_oitf.sv
// Outstanding-instruction FIFO holding pending load destinations, with itag allocation and hazard match
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_oitf (
  input  wire                          clk,
  input  wire                          i_rst_n,
  // Allocation from dispatch
  input  wire                          i_dis_ena,
  input  wire [`EXU_RFIDX_W-1:0]       i_dis_rdidx,
  // Operands of the instruction in dispatch
  input  wire [`EXU_RFIDX_W-1:0]       i_rs1idx,
  input  wire [`EXU_RFIDX_W-1:0]       i_rs2idx,
  input  wire [`EXU_RFIDX_W-1:0]       i_rdidx,
  input  wire                          i_rs1en,
  input  wire                          i_rs2en,
  input  wire                          i_rdwen,
  output logic                         o_hazard,
  output logic                         o_full,
  output logic [`EXU_ITAG_W-1:0]       o_dis_itag,
  // Retirement from write-back
  input  wire                          i_ret_ena,
  output logic [`EXU_RFIDX_W-1:0]      o_ret_rdidx
);

  logic [`EXU_RFIDX_W-1:0]   rdidx_q [`EXU_OITF_DEPTH];
  logic [`EXU_OITF_DEPTH-1:0] vld_q;
  logic [`EXU_ITAG_W:0]      alc_q;   // Wrap bit on top of the index
  logic [`EXU_ITAG_W:0]      ret_q;
  logic [`EXU_ITAG_W-1:0]    alc_idx;
  logic [`EXU_ITAG_W-1:0]    ret_idx;

  // Next ring position, flipping the wrap bit past the last entry
  function automatic logic [`EXU_ITAG_W:0] ptr_inc(input logic [`EXU_ITAG_W:0] p);
    logic [`EXU_ITAG_W-1:0] idx;
    idx = p[`EXU_ITAG_W-1:0];
    if (idx == `EXU_ITAG_W'(`EXU_OITF_DEPTH - 1)) begin
      return {~p[`EXU_ITAG_W], {`EXU_ITAG_W{1'b0}}};
    end
    return p + 1'b1;
  endfunction

  assign alc_idx     = alc_q[`EXU_ITAG_W-1:0];
  assign ret_idx     = ret_q[`EXU_ITAG_W-1:0];
  assign o_full      = (alc_idx == ret_idx) & (alc_q[`EXU_ITAG_W] != ret_q[`EXU_ITAG_W]);
  assign o_dis_itag  = alc_idx;           // The tail slot is the itag
  assign o_ret_rdidx = rdidx_q[ret_idx];  // Head is the oldest load

  ////////////////////////////////////////////////////////////
  // Pointers and valid bits

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      alc_q <= '0;
      ret_q <= '0;
      vld_q <= '0;
    end else begin
      // Never the same slot: no allocate when full, no retire when empty
      if (i_ret_ena) begin
        ret_q          <= ptr_inc(ret_q);
        vld_q[ret_idx] <= 1'b0;
      end
      if (i_dis_ena) begin
        alc_q          <= ptr_inc(alc_q);
        vld_q[alc_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_dis_ena) begin
      rdidx_q[alc_idx] <= i_dis_rdidx;
    end
  end

  ////////////////////////////////////////////////////////////
  // Hazard match, RAW on sources and WAW on the destination

  always_comb begin
    o_hazard = 1'b0;
    for (int i = 0; i < `EXU_OITF_DEPTH; i++) begin
      if (vld_q[i] & ((i_rs1en & (rdidx_q[i] == i_rs1idx)) |
                      (i_rs2en & (rdidx_q[i] == i_rs2idx)) |
                      (i_rdwen & (rdidx_q[i] == i_rdidx)))) begin
        o_hazard = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/exu_pkg.sv
design/exu_regfile.sv
design/exu_wbck.sv
exu_oitf/exu_oitf.sv
exu_disp/exu_disp.sv
design/exu_top.sv
verification/tb_clkgen.sv
verification/exu_asserts.sv
verification/tb_exu.sv

// File: verification/exu_asserts.sv
// Concurrent checks on OITF bookkeeping and the load command handshake, bound into the DUT top
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_asserts (
  input wire                     clk,
  input wire                     i_rst_n,
  input wire                     i_alc_ena,
  input wire                     i_oitf_full,
  input wire                     i_ret_ena,
  input wire [`EXU_ITAG_W-1:0]   i_ret_idx,
  input wire                     i_lsu_wbck_valid,
  input wire exu_pkg::lsu_wbck_t i_lsu_wbck,
  input wire                     i_lsu_cmd_valid,
  input wire exu_pkg::lsu_cmd_t  i_lsu_cmd,
  input wire                     i_lsu_cmd_ready
);

  localparam int cnt_w = `EXU_ITAG_W + 1;

  logic [cnt_w-1:0] cnt_q;  // Shadow occupancy

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + cnt_w'(i_alc_ena) - cnt_w'(i_ret_ena);
    end
  end

  ////////////////////////////////////////////////////////////
  // Properties

  a_no_alloc_full: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_alc_ena |-> (cnt_q < cnt_w'(`EXU_OITF_DEPTH)))
    else $error("OITF allocated while full");

  // Full flag agrees with the shadow occupancy
  a_full_flag: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_oitf_full == (cnt_q == cnt_w'(`EXU_OITF_DEPTH)))
    else $error("OITF full flag disagrees with its occupancy");

  a_no_ret_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_ret_ena |-> (cnt_q != '0)) else $error("OITF retired while empty");

  // Loads come back in order, so the head tag must match
  a_ret_itag: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_lsu_wbck_valid |-> (i_lsu_wbck.itag == i_ret_idx))
    else $error("Returned itag differs from the OITF head");

  a_cmd_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_lsu_cmd_valid && !i_lsu_cmd_ready) |=> (i_lsu_cmd_valid && $stable(i_lsu_cmd)))
    else $error("Load command changed while waiting for ready");

endmodule

bind exu_top exu_asserts exu_asserts_inst (
  .clk              (clk),
  .i_rst_n          (i_rst_n),
  .i_alc_ena        (disp_oitf_ena),
  .i_oitf_full      (oitf_full),
  .i_ret_ena        (ret_ena),
  .i_ret_idx        (u_exu_oitf.ret_idx),
  .i_lsu_wbck_valid (i_lsu_wbck_valid),
  .i_lsu_wbck       (i_lsu_wbck),
  .i_lsu_cmd_valid  (o_lsu_cmd_valid),
  .i_lsu_cmd        (o_lsu_cmd),
  .i_lsu_cmd_ready  (i_lsu_cmd_ready)
);

`default_nettype wire

// File: verification/tb_clkgen.sv
// Clock and reset source of the testbench, with period and reset length set by parameters
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int period_ns  = 8,
  parameter int rst_cycles = 8
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(period_ns / 2) o_clk = ~o_clk;
  end

  // Reset held for whole cycles, released on a falling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (rst_cycles) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_exu.sv
// Testbench of the execution stage: random program, LSU model, reference model and write checks
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module tb_exu;

  localparam int n_instr    = 200;
  localparam int rst_cycles = 8;
  localparam int max_cycles = rst_cycles + 40 * n_instr;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;

  logic               clk;
  logic               rst_n;
  logic               instr_valid;
  exu_pkg::instr_t    instr;
  logic               instr_ready;
  logic               lsu_cmd_valid;
  exu_pkg::lsu_cmd_t  lsu_cmd;
  logic               lsu_cmd_ready;
  logic               lsu_wbck_valid;
  exu_pkg::lsu_wbck_t lsu_wbck;
  logic               rf_wbck_ena;
  exu_pkg::rf_wbck_t  rf_wbck;

  logic [31:0]        lfsr;
  logic [31:0]        prog [n_instr];
  logic [31:0]        model_rf [32];
  logic [31:0]        exp_q [32][$];  // Expected writes per destination
  logic [31:0]        addr_q [$];     // Expected load addresses in order
  exu_pkg::lsu_wbck_t ret_q [$];      // LSU model, loads waiting to return
  int                 due_q [$];
  exu_pkg::lsu_wbck_t lsu_ret;
  logic [31:0]        exp_val;
  int                 exp_cnt;
  int                 wr_cnt;
  int                 cmd_cnt;
  int                 ret_cnt;
  int                 cyc;

  tb_clkgen #(.period_ns(8), .rst_cycles(rst_cycles)) clkgen_inst (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  exu_top exu_top_inst (
    .clk              (clk),
    .i_rst_n          (rst_n),
    .i_instr_valid    (instr_valid),
    .i_instr          (instr),
    .o_instr_ready    (instr_ready),
    .o_lsu_cmd_valid  (lsu_cmd_valid),
    .o_lsu_cmd        (lsu_cmd),
    .i_lsu_cmd_ready  (lsu_cmd_ready),
    .i_lsu_wbck_valid (lsu_wbck_valid),
    .i_lsu_wbck       (lsu_wbck),
    .o_rf_wbck_ena    (rf_wbck_ena),
    .o_rf_wbck        (rf_wbck)
  );

  ////////////////////////////////////////////////////////////
  // Helpers

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] draw_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
  endfunction

  // Memory contents seen by the LSU model
  function automatic logic [31:0] load_data(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
  endfunction

  function automatic logic [31:0] random_instr();
    logic [3:0]  kind;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [11:0] imm;
    logic [31:0] ir;
    kind = 4'(draw_bits(4));
    rs1  = 5'(draw_bits(3));  // x0 to x7 keeps hazards frequent
    rs2  = 5'(draw_bits(3));
    rd   = 5'(draw_bits(3));
    imm  = 12'(draw_bits(12));
    case (kind)
      4'd0:    ir = {7'b0000000, rs2, rs1, 3'b000, rd, opc_op};
      4'd1:    ir = {7'b0100000, rs2, rs1, 3'b000, rd, opc_op};
      4'd2:    ir = {7'b0000000, rs2, rs1, 3'b111, rd, opc_op};
      4'd3:    ir = {7'b0000000, rs2, rs1, 3'b110, rd, opc_op};
      4'd4:    ir = {7'b0000000, rs2, rs1, 3'b100, rd, opc_op};
      4'd5:    ir = {imm, rs1, 3'b000, rd, opc_op_imm};
      4'd6:    ir = {imm, rs1, 3'b111, rd, opc_op_imm};
      4'd7:    ir = {imm, rs1, 3'b110, rd, opc_op_imm};
      4'd8:    ir = {imm, rs1, 3'b100, rd, opc_op_imm};
      4'd13:   ir = {7'b0000001, rs2, rs1, 3'b000, rd, opc_op};  // MUL
      4'd14:   ir = {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b1100011};  // BEQ
      4'd15:   ir = {imm, rs1, 3'b010, rd, opc_op_imm};  // SLTI
      default: ir = {imm, rs1, 3'b010, rd, opc_load};
    endcase
    return ir;
  endfunction

  // Reference model, in program order over the model register file
  function automatic void ref_exec(input logic [31:0] ir);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic        wr;
    opc = ir[6:0];
    f3  = ir[14:12];
    f7  = ir[31:25];
    a   = model_rf[ir[19:15]];
    b   = model_rf[ir[24:20]];
    imm = {{20{ir[31]}}, ir[31:20]};
    res = '0;
    wr  = 1'b1;
    if (opc == opc_op && f7 == 7'b0000000 && f3 == 3'b000) res = a + b;
    else if (opc == opc_op && f7 == 7'b0100000 && f3 == 3'b000) res = a - b;
    else if (opc == opc_op && f7 == 7'b0000000 && f3 == 3'b111) res = a & b;
    else if (opc == opc_op && f7 == 7'b0000000 && f3 == 3'b110) res = a | b;
    else if (opc == opc_op && f7 == 7'b0000000 && f3 == 3'b100) res = a ^ b;
    else if (opc == opc_op_imm && f3 == 3'b000) res = a + imm;
    else if (opc == opc_op_imm && f3 == 3'b111) res = a & imm;
    else if (opc == opc_op_imm && f3 == 3'b110) res = a | imm;
    else if (opc == opc_op_imm && f3 == 3'b100) res = a ^ imm;
    else if (opc == opc_load && f3 == 3'b010) begin
      addr_q.push_back(a + imm);  // Issued even when rd is x0
      res = load_data(a + imm);
    end else wr = 1'b0;
    if (wr && ir[11:7] != 5'd0) begin
      model_rf[ir[11:7]] = res;
      exp_q[ir[11:7]].push_back(res);
      exp_cnt++;
    end
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %0t: %s got %08h expected %08h", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Program and instruction driver

  initial begin
    instr_valid    = 1'b0;
    instr          = '0;
    lsu_cmd_ready  = 1'b0;
    lsu_wbck_valid = 1'b0;
    lsu_wbck       = '0;
    lfsr           = 32'h5f21;
    exp_cnt        = 0;
    wr_cnt         = 0;
    cmd_cnt        = 0;
    ret_cnt        = 0;
    cyc            = 0;
    for (int r = 0; r < 32; r++) model_rf[r] = '0;
    for (int i = 0; i < n_instr; i++) begin
      prog[i] = random_instr();
      ref_exec(prog[i]);
    end
    wait (rst_n === 1'b1);
    for (int i = 0; i < n_instr; i++) begin
      @(negedge clk);
      instr_valid = 1'b1;
      instr.pc    = 32'(4 * i);
      instr.ir    = prog[i];
      @(posedge clk);
      while (!instr_ready) @(posedge clk);  // Held until accepted
    end
    @(negedge clk);
    instr_valid = 1'b0;
    while (ret_cnt != cmd_cnt) @(negedge clk);  // Loads still in flight
    repeat (4) @(negedge clk);
    check_eq("write count", wr_cnt, exp_cnt);
    check_eq("loads not issued", addr_q.size(), 0);
    $display("Testbench passed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // LSU model and timeout, on the falling edge

  always @(negedge clk) begin
    cyc = cyc + 1;
    if (cyc > max_cycles) begin
      stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", max_cycles));
    end else begin
      lsu_cmd_ready  = (draw_bits(1) != 0);
      lsu_wbck_valid = 1'b0;
      if (ret_q.size() != 0 && due_q[0] <= cyc) begin
        lsu_wbck_valid = 1'b1;
        lsu_wbck       = ret_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Comparison on the rising edge

  always @(posedge clk) begin
    if (rst_n) begin
      if (lsu_cmd_valid && lsu_cmd_ready) begin
        if (addr_q.size() == 0) begin
          stop_on_error("Load command issued with no load left in the program");
        end else begin
          exp_val = addr_q.pop_front();
          check_eq("load address", lsu_cmd.addr, exp_val);
          check_eq("load itag", lsu_cmd.itag, cmd_cnt % `EXU_OITF_DEPTH);
          lsu_ret.wdat = load_data(lsu_cmd.addr);
          lsu_ret.itag = lsu_cmd.itag;
          ret_q.push_back(lsu_ret);
          due_q.push_back(cyc + int'(draw_bits(3)) + 1);  // 1 to 8 cycles
          cmd_cnt++;
        end
      end
      if (lsu_wbck_valid) ret_cnt++;
      if (cmd_cnt - ret_cnt > `EXU_OITF_DEPTH) begin
        stop_on_error("More than four loads outstanding");
      end
      if (rf_wbck_ena) begin
        if (rf_wbck.rdidx == '0) begin
          stop_on_error("Write-back enabled for register x0");
        end else if (exp_q[rf_wbck.rdidx].size() == 0) begin
          stop_on_error($sformatf("Unexpected write to x%0d", rf_wbck.rdidx));
        end else begin
          exp_val = exp_q[rf_wbck.rdidx].pop_front();
          check_eq($sformatf("x%0d write", rf_wbck.rdidx), rf_wbck.wdat, exp_val);
          wr_cnt++;
        end
      end
    end
  end

endmodule

`default_nettype wire
